//--- src/la_config.svh
// Logic analyzer configuration
// Bus window, register offsets, lane count and reset words
`ifndef LA_CONFIG_SVH
`define LA_CONFIG_SVH

// Only bits 31:8 are compared
`define LA_BASE_ADR 32'h2200_0000

// Lane groups, four words each
`define LA_DATA_OFS 8'h00
`define LA_OENB_OFS 8'h10
`define LA_IENA_OFS 8'h20

`define LA_PERIOD_OFS 8'h30
`define LA_COUNT_OFS 8'h34

// Four snapshot words
`define LA_SNAP_OFS 8'h40

`define LA_LANES 4

`define LA_OENB_RESET 32'hFFFF_FFFF
`define LA_IENA_RESET 32'h0000_0000

`endif

//--- src/la_bus_pkg.sv
// Bus-side types for the logic analyzer
// Word, byte strobe and register offset of the Wishbone slave port
package la_bus_pkg;

    // Wishbone data and address word
    typedef logic [31:0] bus_word_t;

    // One strobe per byte lane of a word
    typedef logic [3:0] bus_strb_t;

    // Offset inside the 256 byte window
    typedef logic [7:0] bus_ofs_t;

endpackage

//--- src/la_probe_pkg.sv
// Probe-side types for the logic analyzer
// Probe vectors, register groups, lane numbers and sample count
`include "la_config.svh"

package la_probe_pkg;

    // Lane 0 sits in the low bits
    typedef logic [`LA_LANES*32-1:0] probe_vec_t;

    typedef logic [1:0] lane_idx_t;

    // Register group picked by the address decoder
    typedef enum logic [2:0] {
        SEL_DATA,
        SEL_OENB,
        SEL_IENA,
        SEL_PERIOD,
        SEL_COUNT,
        SEL_SNAP,
        SEL_NONE
    } reg_sel_t;

    typedef logic [31:0] sample_cnt_t;

endpackage

//--- src/la_bus_fsm.sv
// Wishbone slave control for the logic analyzer
// Cycle FSM, offset decoder, write enables and registered read mux
`timescale 1ns/1ps
`include "la_config.svh"

module la_bus_fsm (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    cyc_i,
    input  logic                    stb_i,
    input  logic                    we_i,
    input  la_bus_pkg::bus_strb_t   sel_i,
    input  la_bus_pkg::bus_word_t   adr_i,
    input  la_bus_pkg::bus_word_t   dat_i,
    output logic                    ack_o,
    output la_bus_pkg::bus_word_t   dat_o,
    output logic [`LA_LANES-1:0]    data_we_o,
    output logic [`LA_LANES-1:0]    oenb_we_o,
    output logic [`LA_LANES-1:0]    iena_we_o,
    output logic                    period_we_o,
    output la_bus_pkg::bus_strb_t   wstrb_o,
    output la_bus_pkg::bus_word_t   wdata_o,
    input  la_probe_pkg::probe_vec_t probe_in_i,
    input  la_probe_pkg::probe_vec_t data_i,
    input  la_probe_pkg::probe_vec_t oenb_i,
    input  la_probe_pkg::probe_vec_t iena_i,
    input  la_probe_pkg::probe_vec_t snap_i,
    input  la_bus_pkg::bus_word_t   period_i,
    input  la_probe_pkg::sample_cnt_t count_i
);

    typedef enum logic {IDLE, ACK} state_t;

    localparam la_bus_pkg::bus_word_t BASE_ADR = `LA_BASE_ADR;
    // Clears the lane bits 3:2 of an offset
    localparam la_bus_pkg::bus_ofs_t LANE_MASK = 8'hF3;
    localparam logic [`LA_LANES-1:0] LANE_ONE = 1;

    state_t                  state_q;
    la_bus_pkg::bus_ofs_t    ofs;
    la_probe_pkg::lane_idx_t lane;
    la_probe_pkg::reg_sel_t  sel;
    la_bus_pkg::bus_word_t   rd_word;
    logic                    accept;
    logic                    wr;

    assign ofs    = adr_i[7:0];
    assign lane   = ofs[3:2];
    assign accept = (state_q == IDLE) && cyc_i && stb_i && (adr_i[31:8] == BASE_ADR[31:8]);
    assign wr     = accept && we_i;

    always_comb begin
        sel = la_probe_pkg::SEL_NONE;
        if ((ofs & LANE_MASK) == `LA_DATA_OFS)
            sel = la_probe_pkg::SEL_DATA;
        else if ((ofs & LANE_MASK) == `LA_OENB_OFS)
            sel = la_probe_pkg::SEL_OENB;
        else if ((ofs & LANE_MASK) == `LA_IENA_OFS)
            sel = la_probe_pkg::SEL_IENA;
        else if ((ofs & LANE_MASK) == `LA_SNAP_OFS)
            sel = la_probe_pkg::SEL_SNAP;
        else if (ofs == `LA_PERIOD_OFS)
            sel = la_probe_pkg::SEL_PERIOD;
        else if (ofs == `LA_COUNT_OFS)
            sel = la_probe_pkg::SEL_COUNT;
    end

    // Data lanes read back the live probe inputs, not the driven value
    always_comb begin
        case (sel)
            la_probe_pkg::SEL_DATA:   rd_word = probe_in_i[32*lane +: 32];
            la_probe_pkg::SEL_OENB:   rd_word = oenb_i[32*lane +: 32];
            la_probe_pkg::SEL_IENA:   rd_word = iena_i[32*lane +: 32];
            la_probe_pkg::SEL_SNAP:   rd_word = snap_i[32*lane +: 32];
            la_probe_pkg::SEL_PERIOD: rd_word = period_i;
            la_probe_pkg::SEL_COUNT:  rd_word = count_i;
            default:                  rd_word = '0;
        endcase
    end

    assign data_we_o   = (wr && sel == la_probe_pkg::SEL_DATA) ? (LANE_ONE << lane) : '0;
    assign oenb_we_o   = (wr && sel == la_probe_pkg::SEL_OENB) ? (LANE_ONE << lane) : '0;
    assign iena_we_o   = (wr && sel == la_probe_pkg::SEL_IENA) ? (LANE_ONE << lane) : '0;
    assign period_we_o = wr && (sel == la_probe_pkg::SEL_PERIOD);
    assign wstrb_o     = sel_i;
    assign wdata_o     = dat_i;

    // One ack cycle, then back to idle for a cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    state_q <= accept ? ACK : IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dat_o <= rd_word;
        end
    end

    assign ack_o = (state_q == ACK);

    a_ack_single: assert property (@(posedge clk) disable iff (!resetn)
        ack_o |=> !ack_o);

    a_we_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({data_we_o, oenb_we_o, iena_we_o, period_we_o}));

    // A full-word data write shows up on the bank outputs on the next cycle
    for (genvar l = 0; l < `LA_LANES; l++) begin : g_wr_chk
        a_data_wr: assert property (@(posedge clk) disable iff (!resetn)
            (data_we_o[l] && (&wstrb_o)) |=> (data_i[32*l +: 32] == $past(wdata_o)));
    end

endmodule

//--- src/la_reg_bank.sv
// Bank of byte-writable 32-bit lanes
// Serves the data, output-enable-bar and input-enable registers
`timescale 1ns/1ps
`include "la_config.svh"

module la_reg_bank #(
    parameter la_bus_pkg::bus_word_t RESET_WORD = '0
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [`LA_LANES-1:0]     we_i,
    input  la_bus_pkg::bus_strb_t    wstrb_i,
    input  la_bus_pkg::bus_word_t    wdata_i,
    output la_probe_pkg::probe_vec_t lanes_o
);

    la_bus_pkg::bus_word_t lane_q [`LA_LANES];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int l = 0; l < `LA_LANES; l++) begin
                lane_q[l] <= RESET_WORD;
            end
        end else begin
            for (int l = 0; l < `LA_LANES; l++) begin
                if (we_i[l]) begin
                    // Only the strobed bytes change
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb_i[b]) begin
                            lane_q[l][8*b +: 8] <= wdata_i[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    for (genvar l = 0; l < `LA_LANES; l++) begin : g_out
        assign lanes_o[32*l +: 32] = lane_q[l];
    end

    a_we_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(we_i));

endmodule

//--- src/la_sample_timer.sv
// Sample period timer
// Down-counter that pulses sample_o once every programmed period
`timescale 1ns/1ps

module la_sample_timer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  period_we_i,
    input  la_bus_pkg::bus_strb_t wstrb_i,
    input  la_bus_pkg::bus_word_t wdata_i,
    output la_bus_pkg::bus_word_t period_o,
    output logic                  sample_o,
    output logic                  period_load_o
);

    la_bus_pkg::bus_word_t period_q;
    la_bus_pkg::bus_word_t period_next;
    la_bus_pkg::bus_word_t cnt_q;

    always_comb begin
        period_next = period_q;
        for (int b = 0; b < 4; b++) begin
            if (wstrb_i[b]) begin
                period_next[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    // A zero period parks the counter at zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            period_q <= '0;
            cnt_q    <= '0;
        end else if (period_we_i) begin
            period_q <= period_next;
            cnt_q    <= period_next;
        end else if (cnt_q == 32'd1) begin
            cnt_q <= period_q;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 32'd1;
        end
    end

    assign period_o      = period_q;
    assign sample_o      = (cnt_q == 32'd1);
    assign period_load_o = period_we_i;

    a_no_sample_when_off: assert property (@(posedge clk) disable iff (!resetn)
        sample_o |-> (period_o != '0));

endmodule

//--- src/la_capture.sv
// Probe capture
// Latches the enabled probe inputs on each sample and counts samples
`timescale 1ns/1ps

module la_capture (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      sample_i,
    input  logic                      clear_i,
    input  la_probe_pkg::probe_vec_t  probe_in_i,
    input  la_probe_pkg::probe_vec_t  iena_i,
    output la_probe_pkg::probe_vec_t  snap_o,
    output la_probe_pkg::sample_cnt_t count_o
);

    la_probe_pkg::probe_vec_t  snap_q;
    la_probe_pkg::sample_cnt_t count_q;

    // A new period clears the history, even on a sample edge
    always_ff @(posedge clk) begin
        if (!resetn || clear_i) begin
            snap_q  <= '0;
            count_q <= '0;
        end else if (sample_i) begin
            snap_q  <= probe_in_i & iena_i;
            count_q <= count_q + 32'd1;
        end
    end

    assign snap_o  = snap_q;
    assign count_o = count_q;

endmodule

//--- src/la_wb.sv
// Logic analyzer probe block with a Wishbone slave port
// Probe data, enables and a periodic snapshot sampler
`timescale 1ns/1ps
`include "la_config.svh"

module la_wb (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  la_bus_pkg::bus_strb_t    wb_sel_i,
    input  la_bus_pkg::bus_word_t    wb_adr_i,
    input  la_bus_pkg::bus_word_t    wb_dat_i,
    output logic                     wb_ack_o,
    output la_bus_pkg::bus_word_t    wb_dat_o,
    input  la_probe_pkg::probe_vec_t la_data_in_i,
    output la_probe_pkg::probe_vec_t la_data_o,
    output la_probe_pkg::probe_vec_t la_oenb_o,
    output la_probe_pkg::probe_vec_t la_iena_o
);

    logic [`LA_LANES-1:0]      data_we;
    logic [`LA_LANES-1:0]      oenb_we;
    logic [`LA_LANES-1:0]      iena_we;
    logic                      period_we;
    la_bus_pkg::bus_strb_t     wstrb;
    la_bus_pkg::bus_word_t     wdata;
    la_bus_pkg::bus_word_t     period;
    logic                      sample;
    logic                      period_load;
    la_probe_pkg::probe_vec_t  snap;
    la_probe_pkg::sample_cnt_t count;

    la_bus_fsm u_bus_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .cyc_i       (wb_cyc_i),
        .stb_i       (wb_stb_i),
        .we_i        (wb_we_i),
        .sel_i       (wb_sel_i),
        .adr_i       (wb_adr_i),
        .dat_i       (wb_dat_i),
        .ack_o       (wb_ack_o),
        .dat_o       (wb_dat_o),
        .data_we_o   (data_we),
        .oenb_we_o   (oenb_we),
        .iena_we_o   (iena_we),
        .period_we_o (period_we),
        .wstrb_o     (wstrb),
        .wdata_o     (wdata),
        .probe_in_i  (la_data_in_i),
        .data_i      (la_data_o),
        .oenb_i      (la_oenb_o),
        .iena_i      (la_iena_o),
        .snap_i      (snap),
        .period_i    (period),
        .count_i     (count)
    );

    la_reg_bank #(.RESET_WORD(32'h0000_0000)) data_bank (
        .clk     (clk),
        .resetn  (resetn),
        .we_i    (data_we),
        .wstrb_i (wstrb),
        .wdata_i (wdata),
        .lanes_o (la_data_o)
    );

    // Outputs come up tri-stated
    la_reg_bank #(.RESET_WORD(`LA_OENB_RESET)) oenb_bank (
        .clk     (clk),
        .resetn  (resetn),
        .we_i    (oenb_we),
        .wstrb_i (wstrb),
        .wdata_i (wdata),
        .lanes_o (la_oenb_o)
    );

    la_reg_bank #(.RESET_WORD(`LA_IENA_RESET)) iena_bank (
        .clk     (clk),
        .resetn  (resetn),
        .we_i    (iena_we),
        .wstrb_i (wstrb),
        .wdata_i (wdata),
        .lanes_o (la_iena_o)
    );

    la_sample_timer u_sample_timer (
        .clk           (clk),
        .resetn        (resetn),
        .period_we_i   (period_we),
        .wstrb_i       (wstrb),
        .wdata_i       (wdata),
        .period_o      (period),
        .sample_o      (sample),
        .period_load_o (period_load)
    );

    la_capture u_capture (
        .clk        (clk),
        .resetn     (resetn),
        .sample_i   (sample),
        .clear_i    (period_load),
        .probe_in_i (la_data_in_i),
        .iena_i     (la_iena_o),
        .snap_o     (snap),
        .count_o    (count)
    );

endmodule

//--- tests/la_wb_tb.sv
// Testbench for the logic analyzer probe block
// Directed Wishbone tests of the lanes, address decoding and the sampler
`timescale 1ns/1ps
`include "la_config.svh"

module la_wb_tb;

    localparam int          CLK_PERIOD    = 4;
    localparam int          RESET_CYCLES  = 4;
    localparam int          ACK_LIMIT     = 20;
    localparam logic [31:0] SEED          = 32'h2ce638a1;
    // Worst case per access is the ack limit plus the drive and idle cycles
    localparam int          ACCESS_CYCLES = ACK_LIMIT + 2;
    localparam int          ACCESS_COUNT  = 64;
    localparam int          WAIT_CYCLES   = 140;
    localparam int          MARGIN_CYCLES = 200;
    localparam int          WATCHDOG_NS   = CLK_PERIOD *
        (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES + WAIT_CYCLES + MARGIN_CYCLES);

    logic                     clk;
    logic                     resetn;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    la_bus_pkg::bus_strb_t    wb_sel;
    la_bus_pkg::bus_word_t    wb_adr;
    la_bus_pkg::bus_word_t    wb_dat;
    logic                     wb_ack;
    la_bus_pkg::bus_word_t    wb_rdat;
    la_probe_pkg::probe_vec_t la_data_in;
    la_probe_pkg::probe_vec_t la_data;
    la_probe_pkg::probe_vec_t la_oenb;
    la_probe_pkg::probe_vec_t la_iena;

    // Expected lane contents
    la_bus_pkg::bus_word_t data_m [`LA_LANES];
    la_bus_pkg::bus_word_t oenb_m [`LA_LANES];
    la_bus_pkg::bus_word_t iena_m [`LA_LANES];

    int errors;
    int tests_run;
    int tests_failed;

    la_wb UUT (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_sel_i     (wb_sel),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat),
        .wb_ack_o     (wb_ack),
        .wb_dat_o     (wb_rdat),
        .la_data_in_i (la_data_in),
        .la_data_o    (la_data),
        .la_oenb_o    (la_oenb),
        .la_iena_o    (la_iena)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic la_bus_pkg::bus_word_t lane_adr(la_bus_pkg::bus_ofs_t grp, int lane);
        return `LA_BASE_ADR + 32'(grp) + 32'(4 * lane);
    endfunction

    function automatic la_bus_pkg::bus_word_t merge_bytes(la_bus_pkg::bus_word_t old_word,
            la_bus_pkg::bus_word_t new_word, la_bus_pkg::bus_strb_t strb);
        la_bus_pkg::bus_word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic la_probe_pkg::probe_vec_t pack_lanes(la_bus_pkg::bus_word_t lanes [`LA_LANES]);
        la_probe_pkg::probe_vec_t vec;
        for (int l = 0; l < `LA_LANES; l++) begin
            vec[32*l +: 32] = lanes[l];
        end
        return vec;
    endfunction

    task automatic check_word(input string what, input la_bus_pkg::bus_word_t got,
            input la_bus_pkg::bus_word_t exp);
        assert (got == exp) else begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_vec(input string what, input la_probe_pkg::probe_vec_t got,
            input la_probe_pkg::probe_vec_t exp);
        assert (got == exp) else begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs(input string when);
        check_vec({"la_data_o ", when}, la_data, pack_lanes(data_m));
        check_vec({"la_oenb_o ", when}, la_oenb, pack_lanes(oenb_m));
        check_vec({"la_iena_o ", when}, la_iena, pack_lanes(iena_m));
    endtask

    task automatic drop_request();
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // Holds the request until ack or the limit; on a timeout it is left raised
    task automatic bus_cycle(input logic we, input la_bus_pkg::bus_word_t adr,
            input la_bus_pkg::bus_word_t wdata, input la_bus_pkg::bus_strb_t strb,
            output la_bus_pkg::bus_word_t rdata, output logic acked);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_dat <= wdata;
        wb_sel <= strb;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        acked = wb_ack;
        rdata = wb_rdat;
        if (acked) begin
            drop_request();
        end
    endtask

    task automatic wb_write(input la_bus_pkg::bus_word_t adr, input la_bus_pkg::bus_word_t data,
            input la_bus_pkg::bus_strb_t strb);
        la_bus_pkg::bus_word_t unused_rd;
        logic acked;
        bus_cycle(1'b1, adr, data, strb, unused_rd, acked);
        assert (acked) else begin
            $display("no ack from the DUT within %0d cycles on a write to %h", ACK_LIMIT, adr);
            errors++;
        end
        if (!acked) begin
            drop_request();
        end
    endtask

    task automatic wb_read(input la_bus_pkg::bus_word_t adr, output la_bus_pkg::bus_word_t data);
        logic acked;
        bus_cycle(1'b0, adr, '0, 4'hF, data, acked);
        assert (acked) else begin
            $display("no ack from the DUT within %0d cycles on a read of %h", ACK_LIMIT, adr);
            errors++;
        end
        if (!acked) begin
            drop_request();
        end
    endtask

    task automatic read_check(input string what, input la_bus_pkg::bus_word_t adr,
            input la_bus_pkg::bus_word_t exp);
        la_bus_pkg::bus_word_t rd;
        wb_read(adr, rd);
        check_word(what, rd, exp);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_values();
        int start;
        start = errors;
        for (int l = 0; l < `LA_LANES; l++) begin
            data_m[l] = '0;
            oenb_m[l] = `LA_OENB_RESET;
            iena_m[l] = `LA_IENA_RESET;
        end
        check_outputs("after reset");
        for (int l = 0; l < `LA_LANES; l++) begin
            read_check($sformatf("oenb lane %0d read", l), lane_adr(`LA_OENB_OFS, l),
                `LA_OENB_RESET);
            read_check($sformatf("iena lane %0d read", l), lane_adr(`LA_IENA_OFS, l),
                `LA_IENA_RESET);
            read_check($sformatf("snapshot %0d read", l), lane_adr(`LA_SNAP_OFS, l), '0);
        end
        read_check("count read", lane_adr(`LA_COUNT_OFS, 0), '0);
        finish_test("reset_values", start);
    endtask

    task automatic test_byte_writes();
        int start;
        la_bus_pkg::bus_word_t word;
        la_bus_pkg::bus_strb_t strb;
        start = errors;
        for (int l = 0; l < `LA_LANES; l++) begin
            word = $urandom;
            strb = 4'($urandom);
            wb_write(lane_adr(`LA_DATA_OFS, l), word, strb);
            data_m[l] = merge_bytes(data_m[l], word, strb);
            word = $urandom;
            strb = 4'($urandom);
            wb_write(lane_adr(`LA_OENB_OFS, l), word, strb);
            oenb_m[l] = merge_bytes(oenb_m[l], word, strb);
            word = $urandom;
            strb = 4'($urandom);
            wb_write(lane_adr(`LA_IENA_OFS, l), word, strb);
            iena_m[l] = merge_bytes(iena_m[l], word, strb);
        end
        check_outputs("after byte writes");
        for (int l = 0; l < `LA_LANES; l++) begin
            read_check($sformatf("oenb lane %0d read", l), lane_adr(`LA_OENB_OFS, l), oenb_m[l]);
            read_check($sformatf("iena lane %0d read", l), lane_adr(`LA_IENA_OFS, l), iena_m[l]);
        end
        finish_test("byte_writes", start);
    endtask

    task automatic test_data_channels();
        int start;
        la_probe_pkg::probe_vec_t pattern;
        start = errors;
        pattern = {$urandom, $urandom, $urandom, $urandom};
        @(posedge clk);
        la_data_in <= pattern;
        for (int l = 0; l < `LA_LANES; l++) begin
            read_check($sformatf("data lane %0d read", l), lane_adr(`LA_DATA_OFS, l),
                pattern[32*l +: 32]);
        end
        check_vec("la_data_o with probe input driven", la_data, pack_lanes(data_m));
        finish_test("data_channels", start);
    endtask

    task automatic test_address_decode();
        int start;
        la_bus_pkg::bus_word_t rd;
        la_bus_pkg::bus_word_t adr;
        logic acked;
        start = errors;
        wb_write(`LA_BASE_ADR + 32'h38, $urandom, 4'hF);
        read_check("unmapped offset 0x38 read", `LA_BASE_ADR + 32'h38, '0);
        read_check("period after unmapped write", lane_adr(`LA_PERIOD_OFS, 0), '0);
        check_outputs("after unmapped write");
        // Same oenb offset, one window higher
        adr = `LA_BASE_ADR + 32'h100 + 32'(`LA_OENB_OFS);
        bus_cycle(1'b1, adr, 32'h0, 4'hF, rd, acked);
        assert (!acked) else begin
            $display("out-of-window write to %h was acknowledged", adr);
            errors++;
        end
        if (!acked) begin
            $display("no ack for out-of-window address %h within %0d cycles, as expected",
                adr, ACK_LIMIT);
            drop_request();
        end
        check_outputs("after out-of-window write");
        finish_test("address_decode", start);
    endtask

    task automatic test_sampling();
        int start;
        la_probe_pkg::probe_vec_t  pattern;
        la_probe_pkg::sample_cnt_t first_cnt;
        la_probe_pkg::sample_cnt_t second_cnt;
        la_probe_pkg::sample_cnt_t cleared_cnt;
        la_bus_pkg::bus_word_t     word;
        start = errors;
        repeat (50) @(posedge clk);
        read_check("count with period zero", lane_adr(`LA_COUNT_OFS, 0), '0);
        for (int l = 0; l < `LA_LANES; l++) begin
            read_check($sformatf("snapshot %0d with period zero", l),
                lane_adr(`LA_SNAP_OFS, l), '0);
        end
        for (int l = 0; l < `LA_LANES; l++) begin
            word = $urandom;
            wb_write(lane_adr(`LA_IENA_OFS, l), word, 4'hF);
            iena_m[l] = word;
        end
        pattern = {$urandom, $urandom, $urandom, $urandom};
        @(posedge clk);
        la_data_in <= pattern;
        wb_write(lane_adr(`LA_PERIOD_OFS, 0), 32'd5, 4'hF);
        repeat (60) @(posedge clk);
        for (int l = 0; l < `LA_LANES; l++) begin
            read_check($sformatf("snapshot %0d", l), lane_adr(`LA_SNAP_OFS, l),
                pattern[32*l +: 32] & iena_m[l]);
        end
        wb_read(lane_adr(`LA_COUNT_OFS, 0), first_cnt);
        assert (first_cnt != 0) else begin
            $display("mismatch at %0t ns: count read %0d with the period set to 5, expected nonzero",
                $time, first_cnt);
            errors++;
        end
        repeat (20) @(posedge clk);
        wb_read(lane_adr(`LA_COUNT_OFS, 0), second_cnt);
        assert (second_cnt > first_cnt) else begin
            $display("mismatch at %0t ns: count read %0d, expected more than %0d",
                $time, second_cnt, first_cnt);
            errors++;
        end
        // A period write restarts the count
        wb_write(lane_adr(`LA_PERIOD_OFS, 0), 32'd5, 4'hF);
        wb_read(lane_adr(`LA_COUNT_OFS, 0), cleared_cnt);
        assert (cleared_cnt < second_cnt) else begin
            $display("mismatch at %0t ns: count after period write %0d, expected less than %0d",
                $time, cleared_cnt, second_cnt);
            errors++;
        end
        finish_test("sampling", start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] seed_ret;
        clk          = 1'b0;
        resetn       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_sel       = '0;
        wb_adr       = '0;
        wb_dat       = '0;
        la_data_in   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed_ret     = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        test_reset_values();
        test_byte_writes();
        test_data_channels();
        test_address_decode();
        test_sampling();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/la_bus_pkg.sv
src/la_probe_pkg.sv
src/la_bus_fsm.sv
src/la_reg_bank.sv
src/la_sample_timer.sv
src/la_capture.sv
src/la_wb.sv
tests/la_wb_tb.sv

//--- Makefile
# Verilator build and run of the logic analyzer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module la_wb_tb -Mdir obj_dir
	-./obj_dir/Vla_wb_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
